/* icache_pkg.sv */
// Instruction cache geometry, refill states, beat/lookup/line/response structs, slot helper
package icache_pkg;

	// Cache geometry
	localparam int LINE_BEATS = 8;
	localparam int SET_COUNT = 16;
	localparam int OFFSET_W = 6;
	localparam int INDEX_W = 4;
	localparam int TAG_W = 22;
	// Beat index width inside a line
	localparam int BEAT_W = $clog2(LINE_BEATS);

	// Miss handling states
	typedef enum logic [1:0] {
		RF_IDLE = 2'd0,
		RF_REQ = 2'd1,
		RF_GET = 2'd2,
		RF_OUT = 2'd3
	} refill_state_e;

	// One 64-bit beat, lower instruction in the low half
	typedef struct packed {
		logic [63:0] data;
		logic [23:0] flags;
	} mem_beat_t;

	// Registered result of a tag lookup
	typedef struct packed {
		logic valid;
		logic hit;
		logic [31:0] addr;
		logic [63:0] data;
		logic [23:0] flags;
	} lookup_result_t;

	// Whole line, beat 0 in the low bits
	typedef struct packed {
		logic [64*LINE_BEATS-1:0] data;
		logic [24*LINE_BEATS-1:0] flags;
	} fill_line_t;

	// Two instruction slots towards the fetch unit
	typedef struct packed {
		logic slot1_valid;
		logic [31:0] slot1_inst;
		logic [11:0] slot1_flags;
		logic slot0_valid;
		logic [31:0] slot0_inst;
		logic [11:0] slot0_flags;
	} fetch_resp_t;

	// Slot 0 gets the addressed word, slot 1 the upper word when bit 2 is clear
	function automatic fetch_resp_t arrange_slots(input logic [63:0] data,
			input logic [23:0] flags, input logic upper);
		fetch_resp_t resp;
		resp.slot0_valid = 1'b1;
		resp.slot0_inst = upper ? data[63:32] : data[31:0];
		resp.slot0_flags = upper ? flags[23:12] : flags[11:0];
		resp.slot1_valid = !upper;
		resp.slot1_inst = data[63:32];
		resp.slot1_flags = flags[23:12];
		return resp;
	endfunction

endpackage

/* icache_line_array.sv */
// Direct-mapped tag, valid and line storage with registered lookup and whole-line fill
`timescale 1ns/1ns

module icache_line_array (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic lookup_req,
	input logic [31:0] lookup_addr,
	input logic hold,
	output icache_pkg::lookup_result_t lookup_result,
	input logic fill_req,
	input logic [31:0] fill_addr,
	input icache_pkg::fill_line_t fill_line
);

	// Per-set state
	logic [icache_pkg::SET_COUNT-1:0] valid_q;
	logic [icache_pkg::TAG_W-1:0] tag_q [icache_pkg::SET_COUNT];
	logic [64*icache_pkg::LINE_BEATS-1:0] data_q [icache_pkg::SET_COUNT];
	logic [24*icache_pkg::LINE_BEATS-1:0] flags_q [icache_pkg::SET_COUNT];

	// Lookup address split
	logic [icache_pkg::INDEX_W-1:0] lk_index;
	logic [icache_pkg::TAG_W-1:0] lk_tag;
	logic [icache_pkg::BEAT_W-1:0] lk_beat;

	// Fill address split
	logic [icache_pkg::INDEX_W-1:0] fl_index;
	logic [icache_pkg::TAG_W-1:0] fl_tag;

	// Selected line and beat
	logic [64*icache_pkg::LINE_BEATS-1:0] sel_data;
	logic [24*icache_pkg::LINE_BEATS-1:0] sel_flags;
	logic [63:0] beat_data;
	logic [23:0] beat_flags;
	logic tag_match;

	assign lk_index = lookup_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
	assign lk_tag = lookup_addr[31 -: icache_pkg::TAG_W];
	assign lk_beat = lookup_addr[icache_pkg::OFFSET_W-1 -: icache_pkg::BEAT_W];

	assign fl_index = fill_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
	assign fl_tag = fill_addr[31 -: icache_pkg::TAG_W];

	assign sel_data = data_q[lk_index];
	assign sel_flags = flags_q[lk_index];
	assign beat_data = sel_data[lk_beat*64 +: 64];
	assign beat_flags = sel_flags[lk_beat*24 +: 24];
	assign tag_match = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);

	// Valid bits, flush clears all, a fill in the same cycle still lands
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
		end
		else begin
			if (flush) begin
				valid_q <= '0;
			end
			if (fill_req) begin
				valid_q[fl_index] <= 1'b1;
			end
		end
	end

	// Tag and line storage
	always_ff @(posedge iCLOCK) begin
		if (fill_req) begin
			tag_q[fl_index] <= fl_tag;
			data_q[fl_index] <= fill_line.data;
			flags_q[fl_index] <= fill_line.flags;
		end
	end

	// Lookup register, frozen by hold
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lookup_result <= '0;
		end
		else if (lookup_req && !hold) begin
			lookup_result.valid <= 1'b1;
			lookup_result.hit <= tag_match;
			lookup_result.addr <= lookup_addr;
			lookup_result.data <= beat_data;
			lookup_result.flags <= beat_flags;
		end
	end

endmodule

/* icache_refill.sv */
// Miss FSM: issues eight beat requests, assembles the line, keeps the critical beat
`timescale 1ns/1ns

module icache_refill (
	input logic iCLOCK,
	input logic inRESET,
	input logic miss_start,
	input logic [31:0] miss_addr,
	input logic out_lock,
	output logic mem_req,
	output logic [31:0] mem_addr,
	input logic mem_lock,
	input logic mem_valid,
	input icache_pkg::mem_beat_t mem_beat,
	output logic fill_req,
	output logic [31:0] fill_addr,
	output icache_pkg::fill_line_t fill_line,
	output icache_pkg::refill_state_e refill_state,
	output icache_pkg::fetch_resp_t refill_resp
);

	icache_pkg::refill_state_e state;

	// Address of the missing fetch
	logic [31:0] addr_q;
	// Beats requested and beats received
	logic [icache_pkg::BEAT_W-1:0] req_cnt;
	logic [icache_pkg::BEAT_W-1:0] get_cnt;
	// Line being assembled
	icache_pkg::fill_line_t line_q;

	logic beat_in;
	logic last_beat;
	logic critical_beat;

	assign beat_in = mem_valid &&
		(state == icache_pkg::RF_REQ || state == icache_pkg::RF_GET);
	assign last_beat = (get_cnt == icache_pkg::BEAT_W'(icache_pkg::LINE_BEATS - 1));
	assign critical_beat = (get_cnt == addr_q[icache_pkg::OFFSET_W-1 -: icache_pkg::BEAT_W]);

	// State and counters
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= icache_pkg::RF_IDLE;
			addr_q <= '0;
			req_cnt <= '0;
			get_cnt <= '0;
			fill_req <= 1'b0;
		end
		else begin
			fill_req <= 1'b0;
			case (state)
				icache_pkg::RF_IDLE: begin
					if (miss_start) begin
						addr_q <= miss_addr;
						req_cnt <= '0;
						get_cnt <= '0;
						state <= icache_pkg::RF_REQ;
					end
				end
				icache_pkg::RF_REQ: begin
					// Counter wraps to zero on the last accepted request
					if (!mem_lock) begin
						req_cnt <= req_cnt + 1'b1;
						if (req_cnt == icache_pkg::BEAT_W'(icache_pkg::LINE_BEATS - 1)) begin
							state <= icache_pkg::RF_GET;
						end
					end
				end
				icache_pkg::RF_GET: begin
					if (mem_valid && last_beat) begin
						fill_req <= 1'b1;
						state <= icache_pkg::RF_OUT;
					end
				end
				icache_pkg::RF_OUT: begin
					if (!out_lock) begin
						state <= icache_pkg::RF_IDLE;
					end
				end
				default: begin
					state <= icache_pkg::RF_IDLE;
				end
			endcase
			if (beat_in) begin
				get_cnt <= get_cnt + 1'b1;
			end
		end
	end

	// Critical beat arranged into the two slots
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			refill_resp <= '0;
		end
		else if (beat_in && critical_beat) begin
			refill_resp <= icache_pkg::arrange_slots(mem_beat.data, mem_beat.flags,
				addr_q[2]);
		end
	end

	// Beats shift in from the top, beat 0 ends up lowest
	always_ff @(posedge iCLOCK) begin
		if (beat_in) begin
			line_q.data <= {mem_beat.data, line_q.data[64*icache_pkg::LINE_BEATS-1:64]};
			line_q.flags <= {mem_beat.flags, line_q.flags[24*icache_pkg::LINE_BEATS-1:24]};
		end
	end

	assign mem_req = (state == icache_pkg::RF_REQ);
	assign mem_addr = {addr_q[31:icache_pkg::OFFSET_W], req_cnt, 3'b000};
	assign fill_addr = {addr_q[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
	assign fill_line = line_q;
	assign refill_state = state;

endmodule

/* icache_fetch_resp.sv */
// Fetch response stage: acceptance, hit or refill result selection, miss start and fetch lock
`timescale 1ns/1ns

module icache_fetch_resp (
	input logic iCLOCK,
	input logic inRESET,
	input logic fetch_req,
	input logic [31:0] fetch_addr,
	output logic fetch_lock,
	input logic out_lock,
	output icache_pkg::fetch_resp_t fetch_resp,
	output logic lookup_req,
	output logic [31:0] lookup_addr,
	output logic hold,
	input icache_pkg::lookup_result_t lookup_result,
	output logic miss_start,
	input icache_pkg::refill_state_e refill_state,
	input icache_pkg::fetch_resp_t refill_resp
);

	// Lookup result not yet delivered or handed to the refill
	logic pending;

	logic accept;
	logic live;
	logic hit_live;
	logic miss_live;
	icache_pkg::fetch_resp_t hit_resp;

	assign live = pending && lookup_result.valid;
	assign hit_live = live && lookup_result.hit;
	assign miss_live = live && !lookup_result.hit;

	assign fetch_lock = (refill_state != icache_pkg::RF_IDLE) || miss_live ||
		(hit_live && out_lock);
	assign accept = fetch_req && !fetch_lock;

	assign lookup_req = accept;
	assign lookup_addr = fetch_addr;
	assign hold = pending && out_lock;
	assign miss_start = miss_live && !out_lock;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending <= 1'b0;
		end
		else if (accept) begin
			pending <= 1'b1;
		end
		else if ((hit_live && !out_lock) || miss_start) begin
			pending <= 1'b0;
		end
	end

	assign hit_resp = icache_pkg::arrange_slots(lookup_result.data, lookup_result.flags,
		lookup_result.addr[2]);

	// Refill result wins while the miss is being delivered
	always_comb begin
		if (refill_state == icache_pkg::RF_OUT) begin
			fetch_resp = refill_resp;
		end
		else if (hit_live) begin
			fetch_resp = hit_resp;
		end
		else begin
			fetch_resp = '0;
		end
	end

endmodule

/* l1_instruction_cache.sv */
// Instruction cache top: line array, refill FSM and fetch response stage
`timescale 1ns/1ns

module l1_instruction_cache (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	// Fetch side
	input logic fetch_req,
	input logic [31:0] fetch_addr,
	output logic fetch_lock,
	input logic out_lock,
	output icache_pkg::fetch_resp_t fetch_resp,
	// Memory side
	output logic mem_req,
	output logic [31:0] mem_addr,
	input logic mem_lock,
	input logic mem_valid,
	input icache_pkg::mem_beat_t mem_beat
);

	logic lookup_req;
	logic [31:0] lookup_addr;
	logic hold;
	icache_pkg::lookup_result_t lookup_result;
	logic miss_start;
	logic fill_req;
	logic [31:0] fill_addr;
	icache_pkg::fill_line_t fill_line;
	icache_pkg::refill_state_e refill_state;
	icache_pkg::fetch_resp_t refill_resp;

	// Hit path
	icache_line_array u_array (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.lookup_req(lookup_req),
		.lookup_addr(lookup_addr),
		.hold(hold),
		.lookup_result(lookup_result),
		.fill_req(fill_req),
		.fill_addr(fill_addr),
		.fill_line(fill_line)
	);

	// Miss path
	icache_refill u_refill (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.miss_start(miss_start),
		.miss_addr(lookup_result.addr),
		.out_lock(out_lock),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid),
		.mem_beat(mem_beat),
		.fill_req(fill_req),
		.fill_addr(fill_addr),
		.fill_line(fill_line),
		.refill_state(refill_state),
		.refill_resp(refill_resp)
	);

	icache_fetch_resp u_resp (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_lock(fetch_lock),
		.out_lock(out_lock),
		.fetch_resp(fetch_resp),
		.lookup_req(lookup_req),
		.lookup_addr(lookup_addr),
		.hold(hold),
		.lookup_result(lookup_result),
		.miss_start(miss_start),
		.refill_state(refill_state),
		.refill_resp(refill_resp)
	);

endmodule

/* tb_icache_mem.sv */
// Memory responder with random request lock and random in-order response latency
`timescale 1ns/1ns

module tb_icache_mem (
	input logic iCLOCK,
	input logic inRESET,
	input logic mem_req,
	input logic [31:0] mem_addr,
	output logic mem_lock,
	output logic mem_valid,
	output icache_pkg::mem_beat_t mem_beat
);

	integer seed;
	logic [31:0] table_q [64];
	logic [31:0] addr_q [$];
	int due_q [$];
	int cycle;

	function automatic logic [31:0] inst_at(input logic [31:0] a);
		return table_q[a[7:2]] ^ {a[31:2], 2'b00};
	endfunction

	function automatic logic [11:0] flags_at(input logic [31:0] a);
		return table_q[a[7:2]][31:20] ^ a[13:2];
	endfunction

	initial begin
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_beat = '0;
		cycle = 0;
		// Same seed as the testbench top, so both tables match
		seed = 32'h8e26_6366;
		for (int i = 0; i < 64; i++) begin
			table_q[i] = $random(seed);
		end
	end

	always @(posedge iCLOCK) begin
		cycle++;
		if (inRESET && mem_req && !mem_lock) begin
			addr_q.push_back(mem_addr);
			due_q.push_back(cycle + 1 + ($unsigned($random(seed)) % 4));
		end
	end

	// Drive on the falling edge, at most one beat per cycle
	always @(negedge iCLOCK) begin
		mem_lock <= ($unsigned($random(seed)) % 4) == 0;
		mem_valid <= 1'b0;
		if (addr_q.size() > 0 && cycle >= due_q[0]) begin
			mem_valid <= 1'b1;
			mem_beat.data <= {inst_at(addr_q[0] + 4), inst_at(addr_q[0])};
			mem_beat.flags <= {flags_at(addr_q[0] + 4), flags_at(addr_q[0])};
			void'(addr_q.pop_front());
			void'(due_q.pop_front());
		end
	end

endmodule

/* l1_icache_chk.sv */
// Concurrent assertions on memory handshake, response hold, hit timing and fill pulse
`timescale 1ns/1ns

module l1_icache_chk (
	input logic iCLOCK,
	input logic inRESET,
	input logic mem_req,
	input logic [31:0] mem_addr,
	input logic mem_lock,
	input logic out_lock,
	input logic fetch_req,
	input logic fetch_lock,
	input icache_pkg::fetch_resp_t fetch_resp,
	input icache_pkg::lookup_result_t lookup_result,
	input logic fill_req,
	input icache_pkg::refill_state_e refill_state
);

	// Number of failed assertions
	int fail_count = 0;

	// Stalled beat request keeps its address
	mem_stall: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req && mem_lock |=> mem_req && $stable(mem_addr))
		else begin
			$error("mem_addr changed while mem_lock stalled the request");
			fail_count++;
		end

	resp_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fetch_resp.slot0_valid && out_lock |=> $stable(fetch_resp))
		else begin
			$error("fetch_resp changed under out_lock");
			fail_count++;
		end

	// A hit shows up the cycle after acceptance
	hit_timing: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fetch_req && !fetch_lock |=> !lookup_result.hit || fetch_resp.slot0_valid)
		else begin
			$error("hit not delivered one cycle after acceptance");
			fail_count++;
		end

	fill_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fill_req |-> refill_state == icache_pkg::RF_OUT &&
			$past(refill_state) == icache_pkg::RF_GET)
		else begin
			$error("fill_req outside the RF_GET to RF_OUT change");
			fail_count++;
		end

endmodule

bind l1_instruction_cache l1_icache_chk u_chk (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.mem_req(mem_req),
	.mem_addr(mem_addr),
	.mem_lock(mem_lock),
	.out_lock(out_lock),
	.fetch_req(fetch_req),
	.fetch_lock(fetch_lock),
	.fetch_resp(fetch_resp),
	.lookup_result(lookup_result),
	.fill_req(fill_req),
	.refill_state(refill_state)
);

/* tb_l1_icache.sv */
// Testbench top with clock, reset, random fetch stimulus, reference cache model and checks
`timescale 1ns/1ns

module tb_l1_icache;

	localparam int NUM_FETCH = 300;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic fetch_req;
	logic [31:0] fetch_addr;
	logic fetch_lock;
	logic out_lock;
	icache_pkg::fetch_resp_t fetch_resp;
	logic mem_req;
	logic [31:0] mem_addr;
	logic mem_lock;
	logic mem_valid;
	icache_pkg::mem_beat_t mem_beat;

	integer seed;
	logic [31:0] table_q [64];
	// Reference tag state per set
	logic model_valid [icache_pkg::SET_COUNT];
	logic [icache_pkg::TAG_W-1:0] model_tag [icache_pkg::SET_COUNT];
	logic [31:0] beat_addrs [$];
	int errors;
	int checks;
	int delivered;
	int accepted;
	logic timed_out;
	int n;

	l1_instruction_cache u_dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_lock(fetch_lock),
		.out_lock(out_lock),
		.fetch_resp(fetch_resp),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid),
		.mem_beat(mem_beat)
	);

	tb_icache_mem u_mem (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid),
		.mem_beat(mem_beat)
	);

	// Memory contents follow the same rule as the responder
	function automatic logic [31:0] inst_at(input logic [31:0] a);
		return table_q[a[7:2]] ^ {a[31:2], 2'b00};
	endfunction

	function automatic logic [11:0] flags_at(input logic [31:0] a);
		return table_q[a[7:2]][31:20] ^ a[13:2];
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Addresses from three sets with four tags each
	function automatic logic [31:0] pick_addr();
		logic [3:0] sets [3];
		logic [31:0] a;
		sets = '{4'd0, 4'd1, 4'd5};
		a = 32'h1000_0000;
		a[11:10] = 2'($unsigned($random(seed)) % 4);
		a[9:6] = sets[$unsigned($random(seed)) % 3];
		a[5:2] = 4'($unsigned($random(seed)) % 16);
		return a;
	endfunction

	task automatic do_flush();
		@(negedge iCLOCK);
		flush = 1'b1;
		@(negedge iCLOCK);
		flush = 1'b0;
		for (int i = 0; i < icache_pkg::SET_COUNT; i++) begin
			model_valid[i] = 1'b0;
		end
	endtask

	task automatic run_fetch(input logic [31:0] a);
		logic miss;
		logic done;
		int idx;
		idx = a[9:6];
		miss = !model_valid[idx] || (model_tag[idx] != a[31:10]);
		beat_addrs.delete();
		done = 1'b0;
		for (int t = 0; t < 200 && !done; t++) begin
			@(negedge iCLOCK);
			fetch_req = 1'b1;
			fetch_addr = a;
			out_lock = ($unsigned($random(seed)) % 3) == 0;
			#1;
			done = !fetch_lock;
		end
		if (!done) begin
			$display("Timeout: fetch request was never accepted");
			timed_out = 1'b1;
			return;
		end
		accepted++;
		done = 1'b0;
		for (int t = 0; t < 500 && !done; t++) begin
			@(negedge iCLOCK);
			fetch_req = 1'b0;
			out_lock = ($unsigned($random(seed)) % 3) == 0;
			#1;
			done = fetch_resp.slot0_valid && !out_lock;
		end
		if (!done) begin
			$display("Timeout: no response delivered for a fetch");
			timed_out = 1'b1;
			return;
		end
		check_value("slot0_inst", inst_at(a), fetch_resp.slot0_inst);
		check_value("slot0_flags", 32'(flags_at(a)), 32'(fetch_resp.slot0_flags));
		check_value("slot1_valid", 32'(!a[2]), 32'(fetch_resp.slot1_valid));
		if (!a[2]) begin
			check_value("slot1_inst", inst_at(a + 4), fetch_resp.slot1_inst);
			check_value("slot1_flags", 32'(flags_at(a + 4)), 32'(fetch_resp.slot1_flags));
		end
		check_value("beat_count", miss ? 32'd8 : 32'd0, beat_addrs.size());
		for (int i = 0; i < beat_addrs.size() && i < 8; i++) begin
			check_value("beat_addr", {a[31:6], 6'b0} + 32'(8 * i), beat_addrs[i]);
		end
		if (miss) begin
			model_valid[idx] = 1'b1;
			model_tag[idx] = a[31:10];
		end
	endtask

	// Accepted beat requests and delivered responses
	always @(posedge iCLOCK) begin
		if (inRESET) begin
			if (mem_req && !mem_lock) begin
				beat_addrs.push_back(mem_addr);
			end
			if (fetch_resp.slot0_valid && !out_lock) begin
				delivered++;
			end
		end
	end

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK;
	end

	initial begin
		inRESET = 1'b0;
		flush = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		out_lock = 1'b0;
		errors = 0;
		checks = 0;
		delivered = 0;
		accepted = 0;
		timed_out = 1'b0;
		seed = 32'h8e26_6366;
		for (int i = 0; i < 64; i++) begin
			table_q[i] = $random(seed);
		end
		for (int i = 0; i < icache_pkg::SET_COUNT; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
		end
		repeat (5) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		#1;
		check_value("reset_slot0_valid", 32'd0, 32'(fetch_resp.slot0_valid));
		check_value("reset_slot1_valid", 32'd0, 32'(fetch_resp.slot1_valid));
		check_value("reset_mem_req", 32'd0, 32'(mem_req));
		check_value("reset_fetch_lock", 32'd0, 32'(fetch_lock));
		for (n = 0; n < NUM_FETCH && !timed_out; n++) begin
			if (($unsigned($random(seed)) % 20) == 0) begin
				do_flush();
			end
			run_fetch(pick_addr());
		end
		@(negedge iCLOCK);
		check_value("delivered_count", 32'(accepted), 32'(delivered));
		$display("Checks: %0d, errors: %0d, assertion failures: %0d, timeout: %0d",
			checks, errors, u_dut.u_chk.fail_count, timed_out);
		if (errors == 0 && u_dut.u_chk.fail_count == 0 && !timed_out) begin
			$display("TESTS PASSED");
		end
		else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
icache_pkg.sv
icache_line_array.sv
icache_refill.sv
icache_fetch_resp.sv
l1_instruction_cache.sv
tb_icache_mem.sv
l1_icache_chk.sv
tb_l1_icache.sv
